//--- include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

////////////////////////////////////////////////////////////
// Core widths
////////////////////////////////////////////////////////////

// Data, address and instruction bytes share one width
`define CPU_DATA_WIDTH 8

// Number of interrupt request lines
`define CPU_NUM_IRQ 2

////////////////////////////////////////////////////////////
// Fixed addresses
////////////////////////////////////////////////////////////

// Bus address parked here whenever memory is not accessed
`define CPU_IDLE_ADDR 8'hFF

// ROM vectors holding the thread start address per line
`define CPU_VECTOR_A 8'hFF
`define CPU_VECTOR_B 8'hFE

// Program counter increments
`define CPU_PC_STEP1 1
`define CPU_PC_STEP2 2

`endif

//--- hdl/cpuPkg.sv
`include "cpu_config.svh"

package cpuPkg;

    // Data, address and instruction byte
    typedef logic [`CPU_DATA_WIDTH-1:0] byteT;

    // One-hot interrupt request or acknowledge
    typedef logic [`CPU_NUM_IRQ-1:0] ackT;

    ////////////////////////////////////////////////////////////
    // Controller states
    ////////////////////////////////////////////////////////////
    typedef enum logic [4:0] {
        stIdle, stThreadFetch0, stThreadFetch1, stThreadFetch2,
        stDecode,
        stReadSetupA, stReadSetupB, stRead0, stRead1, stRead2,
        stWriteSetupA, stWriteSetupB, stWrite0,
        stMathA, stMathB, stMathWait,
        stBranch0, stBranch1, stBranch2,
        stGoto0, stGoto1, stGoto2,
        stGotoIdle
    } stateT;

    // Low nibble of the instruction byte
    typedef enum logic [3:0] {
        instrReadA    = 4'h0,
        instrReadB    = 4'h1,
        instrWriteA   = 4'h2,
        instrWriteB   = 4'h3,
        instrMathA    = 4'h4,
        instrMathB    = 4'h5,
        instrBranch   = 4'h6,
        instrGoto     = 4'h7,
        instrGotoIdle = 4'h8
    } instrT;

    // High nibble of the instruction byte
    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor,
        aluShiftLeftA, aluShiftRightA, aluIncA, aluDecA,
        aluEq, aluGt, aluLt
    } aluOpT;

    // Program sequencer commands
    typedef enum logic [2:0] {
        pcHold, pcStep1, pcStep2, pcLoadRom, pcVectorA, pcVectorB
    } pcCmdT;

    // Source for a register A or B load
    typedef enum logic [1:0] {
        loadNone, loadBus, loadAlu
    } regLoadT;

endpackage

//--- hdl/cpuCtrlIf.sv
`timescale 1ns/1ps

// Command and status bundle between the controller, the
// program sequencer and the data path
interface cpuCtrlIf import cpuPkg::*; ();

    // Program counter command, applied on the next edge
    pcCmdT   pcCmd;
    // Level that adds one to the next cycle's ROM address
    logic    fetchOffset;

    // Register load source and target, 0 is A and 1 is B
    regLoadT regLoad;
    logic    regTarget;

    // Strobe to capture romData as the bus address
    logic    busAddrLoad;
    // Strobe to drive the target register onto the bus with busWe
    logic    busWrite;

    // Registered ALU compare outcome
    logic    branchTaken;

    modport controller (
        output pcCmd,
        output fetchOffset,
        output regLoad,
        output regTarget,
        output busAddrLoad,
        output busWrite,
        input  branchTaken
    );

    modport sequencer (
        input pcCmd,
        input fetchOffset
    );

    modport dataPath (
        input  regLoad,
        input  regTarget,
        input  busAddrLoad,
        input  busWrite,
        output branchTaken
    );

endinterface

//--- hdl/alu.sv
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  byteT  inA,
    input  byteT  inB,
    input  aluOpT op,
    output byteT  result
);

    ////////////////////////////////////////////////////////////
    // Combinational operation select
    ////////////////////////////////////////////////////////////
    always_comb begin
        case (op)
            // Arithmetic wraps modulo 256
            aluAdd: result = inA + inB;
            aluSub: result = inA - inB;

            // Bitwise logic
            aluAnd: result = inA & inB;
            aluOr:  result = inA | inB;
            aluXor: result = inA ^ inB;

            // Single-bit shifts of A, zero filled
            aluShiftLeftA:  result = inA << 1;
            aluShiftRightA: result = inA >> 1;

            // Increment and decrement of A
            aluIncA: result = inA + byteT'(1);
            aluDecA: result = inA - byteT'(1);

            // Unsigned compares give one or zero, used by branches
            aluEq: result = byteT'(inA == inB);
            aluGt: result = byteT'(inA > inB);
            aluLt: result = byteT'(inA < inB);

            // Spare codes 12 to 15
            default: result = '0;
        endcase
    end

endmodule

//--- hdl/programSequencer.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module programSequencer import cpuPkg::*; (
    input  logic  CLK,
    input  logic  RESET,
    output byteT  romAddress,
    cpuCtrlIf.sequencer ctrl,
    input  byteT  romData
);

    // Program counter points at the current opcode
    byteT pc;
    // Offset selects the operand byte that follows the opcode
    logic offsetQ;

    ////////////////////////////////////////////////////////////
    // Program counter and fetch offset
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (RESET) begin
            // Park on the line 0 vector
            pc      <= `CPU_VECTOR_A;
            offsetQ <= 1'b0;
        end else begin
            offsetQ <= ctrl.fetchOffset;
            case (ctrl.pcCmd)
                pcStep1:   pc <= pc + byteT'(`CPU_PC_STEP1);
                pcStep2:   pc <= pc + byteT'(`CPU_PC_STEP2);
                // Jump target or thread start on romData
                pcLoadRom: pc <= romData;
                pcVectorA: pc <= `CPU_VECTOR_A;
                pcVectorB: pc <= `CPU_VECTOR_B;
                default:   pc <= pc;
            endcase
        end
    end

    // ROM sees opcode or operand address, wrapping modulo 256
    assign romAddress = pc + byteT'(offsetQ);

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    pcStableOnHold: assert property (@(posedge CLK) disable iff (RESET)
        ctrl.pcCmd == pcHold |=> $stable(pc))
        else $error("PC moved under a hold command");

endmodule

//--- hdl/dataPath.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module dataPath import cpuPkg::*; (
    input  logic  CLK,
    input  logic  RESET,
    input  byteT  busDataIn,
    input  byteT  romData,
    output byteT  busDataOut,
    output byteT  busAddr,
    output logic  busWe,
    cpuCtrlIf.dataPath ctrl
);

    // Working registers
    byteT  regA;
    byteT  regB;

    byteT  aluResult;
    aluOpT aluOp;
    // Value headed for A or B
    byteT  loadData;

    // ALU operation sits in the high nibble of the opcode
    assign aluOp = aluOpT'(romData[7:4]);

    alu aluInst (
        .inA    (regA),
        .inB    (regB),
        .op     (aluOp),
        .result (aluResult)
    );

    ////////////////////////////////////////////////////////////
    // Register file
    ////////////////////////////////////////////////////////////
    assign loadData = (ctrl.regLoad == loadBus) ? busDataIn : aluResult;

    always_ff @(posedge CLK) begin
        if (ctrl.regLoad != loadNone) begin
            if (ctrl.regTarget)
                regB <= loadData;
            else
                regA <= loadData;
        end
    end

    ////////////////////////////////////////////////////////////
    // Bus outputs and branch status
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr          <= `CPU_IDLE_ADDR;
            busWe            <= 1'b0;
            ctrl.branchTaken <= 1'b0;
        end else begin
            // Address holds for a single cycle, then parks again
            busAddr          <= ctrl.busAddrLoad ? romData : `CPU_IDLE_ADDR;
            busWe            <= ctrl.busWrite;
            // Compare ops yield exactly one when true
            ctrl.branchTaken <= (aluResult == byteT'(1));
        end
    end

    // Write data follows the selected register
    always_ff @(posedge CLK) begin
        if (ctrl.busWrite)
            busDataOut <= ctrl.regTarget ? regB : regA;
    end

endmodule

//--- hdl/cpuController.sv
`timescale 1ns/1ps

module cpuController import cpuPkg::*; (
    input  logic  CLK,
    input  logic  RESET,
    input  byteT  romData,
    input  ackT   interruptRaise,
    output ackT   interruptAck,
    cpuCtrlIf.controller ctrl
);

    stateT state, nextState;
    ackT   nextAck;
    // Register target latched in the read and write setup states
    logic  regSel;
    instrT instr;

    // Instruction nibble of the byte currently on romData
    assign instr = instrT'(romData[3:0]);

    ////////////////////////////////////////////////////////////
    // State, acknowledge and target registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge CLK) begin
        if (RESET) begin
            state        <= stIdle;
            interruptAck <= '0;
            regSel       <= 1'b0;
        end else begin
            state        <= nextState;
            interruptAck <= nextAck;
            if (state == stReadSetupA || state == stWriteSetupA)
                regSel <= 1'b0;
            else if (state == stReadSetupB || state == stWriteSetupB)
                regSel <= 1'b1;
        end
    end

    // Math states name their own target, the rest use the latch
    always_comb begin
        case (state)
            stMathA: ctrl.regTarget = 1'b0;
            stMathB: ctrl.regTarget = 1'b1;
            default: ctrl.regTarget = regSel;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Next state and command decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        nextState        = state;
        nextAck          = '0;
        ctrl.pcCmd       = pcHold;
        ctrl.fetchOffset = 1'b0;
        ctrl.regLoad     = loadNone;
        ctrl.busAddrLoad = 1'b0;
        ctrl.busWrite    = 1'b0;

        case (state)
            // Line 0 wins when both lines are raised
            stIdle: begin
                if (interruptRaise[0]) begin
                    nextState  = stThreadFetch0;
                    nextAck    = 2'b01;
                    ctrl.pcCmd = pcVectorA;
                end else if (interruptRaise[1]) begin
                    nextState  = stThreadFetch0;
                    nextAck    = 2'b10;
                    ctrl.pcCmd = pcVectorB;
                end
            end

            // Vector address goes out to ROM
            stThreadFetch0: nextState = stThreadFetch1;

            // Vector contents arrive, take them as the PC
            stThreadFetch1: begin
                nextState  = stThreadFetch2;
                ctrl.pcCmd = pcLoadRom;
            end

            // First instruction is being fetched
            stThreadFetch2: nextState = stDecode;

            // Unknown nibbles stall here without touching the PC
            stDecode: begin
                ctrl.fetchOffset = 1'b1;
                case (instr)
                    instrReadA:    nextState = stReadSetupA;
                    instrReadB:    nextState = stReadSetupB;
                    instrWriteA:   nextState = stWriteSetupA;
                    instrWriteB:   nextState = stWriteSetupB;
                    instrMathA:    nextState = stMathA;
                    instrMathB:    nextState = stMathB;
                    instrBranch:   nextState = stBranch0;
                    instrGoto:     nextState = stGoto0;
                    instrGotoIdle: nextState = stGotoIdle;
                    default: begin
                        nextState        = stDecode;
                        ctrl.fetchOffset = 1'b0;
                    end
                endcase
            end

            ////////////////////////////////////////////////////////////
            // Memory read: operand byte, bus address, RAM latency
            stReadSetupA,
            stReadSetupB: nextState = stRead0;

            // Operand byte on romData is the RAM address
            stRead0: begin
                nextState        = stRead1;
                ctrl.busAddrLoad = 1'b1;
            end

            // Step past opcode and operand while RAM answers
            stRead1: begin
                nextState  = stRead2;
                ctrl.pcCmd = pcStep2;
            end

            stRead2: begin
                nextState    = stDecode;
                ctrl.regLoad = loadBus;
            end

            ////////////////////////////////////////////////////////////
            // Memory write: step early so the next opcode is ready
            stWriteSetupA,
            stWriteSetupB: begin
                nextState  = stWrite0;
                ctrl.pcCmd = pcStep2;
            end

            stWrite0: begin
                nextState        = stDecode;
                ctrl.busAddrLoad = 1'b1;
                ctrl.busWrite    = 1'b1;
            end

            ////////////////////////////////////////////////////////////
            // ALU result is ready while the opcode is still on romData
            stMathA,
            stMathB: begin
                nextState    = stMathWait;
                ctrl.regLoad = loadAlu;
                ctrl.pcCmd   = pcStep1;
            end

            stMathWait: nextState = stDecode;

            ////////////////////////////////////////////////////////////
            // Branch: compare registered here, target fetched meanwhile
            stBranch0: begin
                nextState  = stBranch1;
                ctrl.pcCmd = pcStep2;
            end

            // Not taken falls straight through to the next opcode
            stBranch1: begin
                if (ctrl.branchTaken) begin
                    nextState  = stBranch2;
                    ctrl.pcCmd = pcLoadRom;
                end else begin
                    nextState  = stDecode;
                end
            end

            stBranch2: nextState = stDecode;

            ////////////////////////////////////////////////////////////
            // Unconditional jump
            stGoto0: nextState = stGoto1;

            stGoto1: begin
                nextState  = stGoto2;
                ctrl.pcCmd = pcLoadRom;
            end

            stGoto2: nextState = stDecode;

            // End of thread
            stGotoIdle: nextState = stIdle;

            default: nextState = stIdle;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////
    ackOneHot: assert property (@(posedge CLK) disable iff (RESET)
        interruptAck != 2'b11)
        else $error("interruptAck shows both lines");

    // Flags the decode stall on an unknown instruction
    knownInstr: assert property (@(posedge CLK) disable iff (RESET)
        state == stDecode |-> romData[3:0] <= 4'h8)
        else $error("unknown instruction nibble %h", romData[3:0]);

    writeOnlyInWrite0: assert property (@(posedge CLK) disable iff (RESET)
        ctrl.busWrite |-> state == stWrite0)
        else $error("bus write outside write state");

endmodule

//--- hdl/cpuTop.sv
`timescale 1ns/1ps

module cpuTop (
    input  logic         CLK,
    input  logic         RESET,
    input  cpuPkg::byteT busDataIn,
    input  cpuPkg::byteT romData,
    input  cpuPkg::ackT  interruptRaise,
    output cpuPkg::byteT busDataOut,
    output cpuPkg::byteT busAddr,
    output logic         busWe,
    output cpuPkg::byteT romAddress,
    output cpuPkg::ackT  interruptAck
);

    // Controller commands and data path status
    cpuCtrlIf ctrlIf ();

    // Instruction FSM and interrupt entry
    cpuController controllerInst (
        .CLK            (CLK),
        .RESET          (RESET),
        .romData        (romData),
        .interruptRaise (interruptRaise),
        .interruptAck   (interruptAck),
        .ctrl           (ctrlIf.controller)
    );

    // Program counter and ROM addressing
    programSequencer sequencerInst (
        .CLK        (CLK),
        .RESET      (RESET),
        .romAddress (romAddress),
        .ctrl       (ctrlIf.sequencer),
        .romData    (romData)
    );

    // Registers, ALU and bus drivers
    dataPath dataPathInst (
        .CLK        (CLK),
        .RESET      (RESET),
        .busDataIn  (busDataIn),
        .romData    (romData),
        .busDataOut (busDataOut),
        .busAddr    (busAddr),
        .busWe      (busWe),
        .ctrl       (ctrlIf.dataPath)
    );

endmodule

//--- tb/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpuTb import cpuPkg::*; ();

    logic CLK;
    logic RESET;
    byteT busDataIn;
    byteT romData;
    ackT  interruptRaise;
    byteT busDataOut;
    byteT busAddr;
    logic busWe;
    byteT romAddress;
    ackT  interruptAck;

    // Memory images with a RAM mirror for the reference model
    byteT rom [256];
    byteT ram [256];
    byteT refRam [256];
    byteT romAddrQ;
    byteT ramAddrQ;
    byteT romPtr;

    // Reference register state carried between threads
    byteT refA;
    byteT refB;

    // Expected bus writes in program order
    byteT expAddrQ [$];
    byteT expDataQ [$];

    logic [31:0] lfsrState;
    int mismatchCount;
    int failCount;

    cpuTop UUT (
        .CLK            (CLK),
        .RESET          (RESET),
        .busDataIn      (busDataIn),
        .romData        (romData),
        .interruptRaise (interruptRaise),
        .busDataOut     (busDataOut),
        .busAddr        (busAddr),
        .busWe          (busWe),
        .romAddress     (romAddress),
        .interruptAck   (interruptAck)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    ////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////

    // Address seen in one cycle and data driven during the next
    always @(negedge CLK) begin
        romData   = rom[romAddrQ];
        busDataIn = ram[ramAddrQ];
        if (busWe === 1'b1)
            ram[busAddr] = busDataOut;
        romAddrQ = romAddress;
        ramAddrQ = busAddr;
    end

    ////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit
    function automatic byteT randByte();
        byteT value;
        int i;
        value = '0;
        for (i = 0; i < 8; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[6:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic byteT aluModel(input aluOpT op, input byteT a, input byteT b);
        case (op)
            aluAdd:         return byteT'((int'(a) + int'(b)) % 256);
            aluSub:         return byteT'((int'(a) - int'(b) + 256) % 256);
            aluAnd:         return a & b;
            aluOr:          return a | b;
            aluXor:         return a ^ b;
            aluShiftLeftA:  return {a[6:0], 1'b0};
            aluShiftRightA: return {1'b0, a[7:1]};
            aluIncA:        return byteT'((int'(a) + 1) % 256);
            aluDecA:        return byteT'((int'(a) + 255) % 256);
            // Unsigned compares
            aluEq:          return (a == b) ? 8'd1 : 8'd0;
            aluGt:          return (a > b) ? 8'd1 : 8'd0;
            aluLt:          return (a < b) ? 8'd1 : 8'd0;
            default:        return 8'd0;
        endcase
    endfunction

    // Walks the thread behind a vector and queues its writes
    // Returns -1 when the thread never ends
    function automatic int runReference(input byteT vector);
        byteT pc;
        byteT opByte;
        byteT operand;
        byteT aluOut;
        int steps;
        int writes;
        pc = rom[vector];
        writes = 0;
        for (steps = 0; steps < 1000; steps++) begin
            opByte  = rom[pc];
            operand = rom[byteT'(pc + 1)];
            aluOut  = aluModel(aluOpT'(opByte[7:4]), refA, refB);
            case (instrT'(opByte[3:0]))
                instrReadA:  refA = refRam[operand];
                instrReadB:  refB = refRam[operand];
                instrWriteA,
                instrWriteB: begin
                    refRam[operand] = opByte[0] ? refB : refA;
                    expAddrQ.push_back(operand);
                    expDataQ.push_back(refRam[operand]);
                    writes++;
                end
                instrMathA:  refA = aluOut;
                instrMathB:  refB = aluOut;
                instrBranch,
                instrGoto:   ;
                instrGotoIdle: return writes;
                default:     return -1;
            endcase
            // Next opcode address
            case (instrT'(opByte[3:0]))
                instrMathA,
                instrMathB:  pc = byteT'(pc + 1);
                instrGoto:   pc = operand;
                instrBranch: pc = (aluOut == 8'd1) ? operand : byteT'(pc + 2);
                default:     pc = byteT'(pc + 2);
            endcase
        end
        return -1;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////
    task automatic checkWrite(input byteT address, input byteT data);
        byteT expAddr;
        byteT expData;
        if (expAddrQ.size() == 0) begin
            failCount++;
            $display("unexpected bus write of %h to %h at %0t", data, address, $time);
        end else begin
            expAddr = expAddrQ.pop_front();
            expData = expDataQ.pop_front();
            if (address !== expAddr || data !== expData) begin
                mismatchCount++;
                $display("mismatch at %0t: write %h to %h, expected %h to %h",
                         $time, data, address, expData, expAddr);
            end
        end
    endtask

    task automatic checkAck(input ackT got, input ackT expected);
        if (got !== expected) begin
            mismatchCount++;
            $display("mismatch at %0t: interruptAck %b, expected %b", $time, got, expected);
        end
    endtask

    task automatic checkBusAddr(input byteT got);
        if (got !== `CPU_IDLE_ADDR) begin
            mismatchCount++;
            $display("mismatch at %0t: busAddr %h, expected parked %h",
                     $time, got, `CPU_IDLE_ADDR);
        end
    endtask

    task automatic checkRomAddress(input byteT got, input byteT expected);
        if (got !== expected) begin
            mismatchCount++;
            $display("mismatch at %0t: romAddress %h, expected %h", $time, got, expected);
        end
    endtask

    // Every write strobe is checked against the queue
    always @(negedge CLK) begin
        if (RESET === 1'b0 && busWe === 1'b1)
            checkWrite(busAddr, busDataOut);
    end

    ////////////////////////////////////////////////////////////
    // Program builders
    ////////////////////////////////////////////////////////////
    task automatic putByte(input byteT value);
        rom[romPtr] = value;
        romPtr = byteT'(romPtr + 1);
    endtask

    task automatic putInstr(input instrT instr, input aluOpT op);
        putByte({op, instr});
    endtask

    // Each ALU op saved to A then to B and both written out
    task automatic buildMathThread(input byteT start);
        byteT x;
        byteT y;
        int k;
        romPtr = start;
        x = randByte() & 8'h3F;
        y = randByte() & 8'h3F;
        for (k = 0; k < 12; k++) begin
            putInstr(instrReadA, aluAdd);
            putByte(x);
            putInstr(instrReadB, aluAdd);
            putByte(y);
            putInstr(instrMathA, aluOpT'(k));
            putInstr(instrWriteA, aluAdd);
            putByte(byteT'(8'h80 + 2 * k));
            putInstr(instrMathB, aluOpT'(k));
            putInstr(instrWriteB, aluAdd);
            putByte(byteT'(8'h81 + 2 * k));
        end
        putInstr(instrGotoIdle, aluAdd);
    endtask

    // Fall-through marker at C0+2i and taken marker at C1+2i
    task automatic buildBranchThread(input byteT start);
        byteT x;
        byteT y;
        aluOpT cmp;
        int i;
        romPtr = start;
        for (i = 0; i < 4; i++) begin
            x = randByte() & 8'h3F;
            // Block 0 compares a byte with itself
            y = (i == 0) ? x : (randByte() & 8'h3F);
            if (i < 3)
                cmp = aluOpT'(9 + i);
            else
                cmp = aluOpT'(9 + int'(randByte() % 3));
            putInstr(instrReadA, aluAdd);
            putByte(x);
            putInstr(instrReadB, aluAdd);
            putByte(y);
            putInstr(instrBranch, cmp);
            putByte(byteT'(romPtr + 5));
            putInstr(instrWriteA, aluAdd);
            putByte(byteT'(8'hC0 + 2 * i));
            // Skip the taken marker
            putInstr(instrGoto, aluAdd);
            putByte(byteT'(romPtr + 3));
            putInstr(instrWriteB, aluAdd);
            putByte(byteT'(8'hC1 + 2 * i));
        end
        putInstr(instrGotoIdle, aluAdd);
    endtask

    ////////////////////////////////////////////////////////////
    // Sequences
    ////////////////////////////////////////////////////////////
    task automatic checkQuiet(input int cycles);
        repeat (cycles) begin
            @(negedge CLK);
            checkAck(interruptAck, 2'b00);
            checkBusAddr(busAddr);
        end
    endtask

    task automatic runThread(input ackT lines, input ackT expectAck, input byteT vector);
        int waitCount;
        if (runReference(vector) < 0) begin
            failCount++;
            $display("reference model found no end of the thread at vector %h", vector);
        end
        @(negedge CLK);
        interruptRaise = lines;
        waitCount = 0;
        while (interruptAck === 2'b00 && waitCount < 20) begin
            @(negedge CLK);
            waitCount++;
        end
        if (interruptAck === 2'b00) begin
            failCount++;
            $display("no interrupt acknowledge within 20 cycles");
        end else begin
            checkAck(interruptAck, expectAck);
            // Vector address goes out to ROM with the acknowledge
            checkRomAddress(romAddress, vector);
        end
        interruptRaise = 2'b00;
        // Acknowledge lasts one cycle
        @(negedge CLK);
        checkAck(interruptAck, 2'b00);
        waitCount = 0;
        while (UUT.controllerInst.state != stIdle && waitCount < 3000) begin
            @(negedge CLK);
            waitCount++;
        end
        if (UUT.controllerInst.state != stIdle) begin
            failCount++;
            $display("core did not return to idle within 3000 cycles");
        end
        if (expAddrQ.size() != 0) begin
            failCount++;
            $display("%0d expected writes never appeared", expAddrQ.size());
            expAddrQ.delete();
            expDataQ.delete();
        end
    endtask

    initial begin
        RESET          = 1'b1;
        interruptRaise = 2'b00;
        romData        = '0;
        busDataIn      = '0;
        romAddrQ       = '0;
        ramAddrQ       = '0;
        refA           = '0;
        refB           = '0;
        mismatchCount  = 0;
        failCount      = 0;
        lfsrState      = 32'h24b3_342e;

        // Random RAM and an address-derived ROM background
        for (int i = 0; i < 256; i++) begin
            ram[i]    = randByte();
            refRam[i] = ram[i];
            rom[i]    = byteT'(i) ^ 8'hA5;
        end
        buildMathThread(8'h00);
        buildBranchThread(8'h80);
        rom[`CPU_VECTOR_A] = 8'h00;
        rom[`CPU_VECTOR_B] = 8'h80;

        repeat (4) @(negedge CLK);
        RESET = 1'b0;

        // Idle after reset
        checkQuiet(20);
        // Both lines raised and line 0 wins
        runThread(2'b11, 2'b01, `CPU_VECTOR_A);
        checkQuiet(20);
        // Line 1 alone runs the branch thread
        runThread(2'b10, 2'b10, `CPU_VECTOR_B);
        checkQuiet(20);
        // Second entry through line 0
        runThread(2'b01, 2'b01, `CPU_VECTOR_A);
        checkQuiet(10);

        $display("errors: %0d mismatches, %0d failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
hdl/cpuPkg.sv
hdl/cpuCtrlIf.sv
hdl/alu.sv
hdl/programSequencer.sv
hdl/dataPath.sv
hdl/cpuController.sv
hdl/cpuTop.sv
tb/cpuTb.sv

//--- Bender.yml
package:
  name: cpuCore

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/cpuPkg.sv
      - hdl/cpuCtrlIf.sv
      - hdl/alu.sv
      - hdl/programSequencer.sv
      - hdl/dataPath.sv
      - hdl/cpuController.sv
      - hdl/cpuTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/cpuTb.sv
